// File: logic/dcache_geom_pkg.sv
package dcache_geom_pkg;

  localparam int NUM_WAYS  = 4;
  localparam int WAY_BITS  = 2;
  localparam int NUM_SETS  = 64;
  localparam int SET_BITS  = 6;
  localparam int NUM_BANKS = 8; // 32-bit words per line
  localparam int OFF_BITS  = 3;
  localparam int TAG_BITS  = 21; // addr[31:11]
  localparam int WORD_BITS = 32;
  localparam int LINE_BITS = 256;

  typedef logic [SET_BITS-1:0] set_t;
  typedef logic [TAG_BITS-1:0] tag_t;
  typedef logic [OFF_BITS-1:0] off_t;
  typedef logic [WAY_BITS-1:0] way_t;
  typedef logic [1:0]          age_t;

  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [LINE_BITS-1:0] line_t;
  typedef logic [3:0]           ben_t;
  typedef logic [NUM_WAYS-1:0]  way_vec_t;

endpackage

// File: logic/dcache_op_pkg.sv
package dcache_op_pkg;

  typedef enum logic [1:0] {
    OP_NONE,
    OP_READ,
    OP_WRITE,
    OP_FILL
  } op_t;

  typedef enum logic {
    INIT_SWEEP,
    INIT_DONE
  } init_state_t;

endpackage

// File: logic/dcache_init_seq.sv
`timescale 1ns/1ps

module dcache_init_seq (
  input  logic                  clk,
  input  logic                  rst,
  output logic                  init,
  output dcache_geom_pkg::set_t init_set
);

  dcache_op_pkg::init_state_t state;

  assign init = (state == dcache_op_pkg::INIT_SWEEP);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= dcache_op_pkg::INIT_SWEEP;
      init_set <= '0;
    end else if (state == dcache_op_pkg::INIT_SWEEP) begin
      init_set <= init_set + 1'b1;
      // last set swept
      if (init_set == dcache_geom_pkg::set_t'(dcache_geom_pkg::NUM_SETS - 1))
        state <= dcache_op_pkg::INIT_DONE;
    end
  end

  // sweep runs once per reset
  a_init_once: assert property (
    @(posedge clk) disable iff (rst)
    !init |=> !init
  );

endmodule

// File: logic/dcache_tag_array.sv
`timescale 1ns/1ps

module dcache_tag_array (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      init,
  input  dcache_geom_pkg::set_t     init_set,
  input  dcache_geom_pkg::set_t     look_set,
  input  dcache_geom_pkg::tag_t     look_tag,
  input  logic                      fill_en,
  input  dcache_geom_pkg::way_t     fill_way,
  output dcache_geom_pkg::way_vec_t hit_way
);

  dcache_geom_pkg::tag_t tag_mem [dcache_geom_pkg::NUM_WAYS][dcache_geom_pkg::NUM_SETS];
  logic valid_mem [dcache_geom_pkg::NUM_WAYS][dcache_geom_pkg::NUM_SETS];

  dcache_geom_pkg::set_t set_q;
  dcache_geom_pkg::tag_t tag_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      set_q <= '0;
      tag_q <= '0;
    end else begin
      set_q <= look_set;
      tag_q <= look_tag;
    end
  end

  // compare all ways of the registered set
  always_comb begin
    for (int w = 0; w < dcache_geom_pkg::NUM_WAYS; w++)
      hit_way[w] = valid_mem[w][set_q] && (tag_mem[w][set_q] == tag_q);
  end

  always_ff @(posedge clk) begin
    if (init) begin
      for (int w = 0; w < dcache_geom_pkg::NUM_WAYS; w++)
        valid_mem[w][init_set] <= 1'b0;
    end else if (fill_en) begin
      tag_mem[fill_way][set_q]   <= tag_q; // stage 1 address
      valid_mem[fill_way][set_q] <= 1'b1;
    end
  end

  // fills go to the victim only, so a line never lives in two ways
  a_hit_onehot: assert property (
    @(posedge clk) disable iff (rst || init)
    $onehot0(hit_way)
  );

endmodule

// File: logic/dcache_lru_array.sv
`timescale 1ns/1ps

module dcache_lru_array (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  init,
  input  dcache_geom_pkg::set_t init_set,
  input  dcache_geom_pkg::set_t look_set,
  input  logic                  touch_en,
  input  dcache_geom_pkg::way_t touch_way,
  output dcache_geom_pkg::way_t victim
);

  dcache_geom_pkg::age_t [dcache_geom_pkg::NUM_WAYS-1:0] age_mem [dcache_geom_pkg::NUM_SETS];

  dcache_geom_pkg::set_t set_q;
  dcache_geom_pkg::age_t [dcache_geom_pkg::NUM_WAYS-1:0] cur;
  dcache_geom_pkg::age_t [dcache_geom_pkg::NUM_WAYS-1:0] upd;
  dcache_geom_pkg::age_t [dcache_geom_pkg::NUM_WAYS-1:0] wr_ages;
  logic [dcache_geom_pkg::NUM_WAYS-1:0] seen;

  always_ff @(posedge clk) begin
    if (rst) set_q <= '0;
    else set_q <= look_set;
  end

  assign cur = age_mem[set_q]; // sees the touch of the cycle before

  always_comb begin
    victim = '0;
    for (int w = 0; w < dcache_geom_pkg::NUM_WAYS; w++)
      if (cur[w] == 2'd3) victim = dcache_geom_pkg::way_t'(w);
  end

  // touched way becomes youngest, younger ones age by one
  always_comb begin
    for (int w = 0; w < dcache_geom_pkg::NUM_WAYS; w++) begin
      if (dcache_geom_pkg::way_t'(w) == touch_way) upd[w] = '0;
      else if (cur[w] < cur[touch_way]) upd[w] = cur[w] + 1'b1;
      else upd[w] = cur[w];
    end
  end

  always_comb begin
    for (int w = 0; w < dcache_geom_pkg::NUM_WAYS; w++)
      wr_ages[w] = init ? dcache_geom_pkg::age_t'(w) : upd[w];
  end

  always_ff @(posedge clk) begin
    if (init) age_mem[init_set] <= wr_ages;
    else if (touch_en) age_mem[set_q] <= wr_ages;
  end

  always_comb begin
    seen = '0;
    for (int w = 0; w < dcache_geom_pkg::NUM_WAYS; w++)
      seen[cur[w]] = 1'b1;
  end

  // ages of a touched set form a permutation
  a_ages_distinct: assert property (
    @(posedge clk) disable iff (rst || init)
    touch_en |-> &seen
  );

endmodule

// File: logic/dcache_bank.sv
`timescale 1ns/1ps

module dcache_bank (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [dcache_geom_pkg::WAY_BITS+dcache_geom_pkg::SET_BITS-1:0] idx,
  input  logic                  rmw_en,
  input  dcache_geom_pkg::ben_t  ben,
  input  dcache_geom_pkg::word_t wdata,
  input  logic                  fill_en,
  input  dcache_geom_pkg::word_t fill_word,
  output dcache_geom_pkg::word_t rd_data
);

  localparam int DEPTH = dcache_geom_pkg::NUM_WAYS * dcache_geom_pkg::NUM_SETS;

  dcache_geom_pkg::word_t ram [DEPTH];

  logic [dcache_geom_pkg::WAY_BITS+dcache_geom_pkg::SET_BITS-1:0] idx_q;
  logic rmw_q;
  dcache_geom_pkg::ben_t  ben_q;
  dcache_geom_pkg::word_t wdata_q;
  dcache_geom_pkg::word_t fill_q;
  dcache_geom_pkg::word_t merged;

  assign rd_data = ram[idx_q];

  always_comb begin
    merged = rd_data;
    for (int i = 0; i < 4; i++)
      if (ben_q[i]) merged[8*i +: 8] = wdata_q[8*i +: 8];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      idx_q <= '0;
      rmw_q <= 1'b0;
    end else begin
      idx_q <= idx;
      rmw_q <= rmw_en;
    end
    ben_q   <= ben;
    wdata_q <= wdata;
    fill_q  <= fill_word; // line arrives with the request
    if (fill_en) ram[idx] <= fill_q;
    else if (rmw_q) ram[idx_q] <= merged;
  end

endmodule

// File: logic/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      init,
  input  dcache_op_pkg::op_t        req_op,
  input  logic [31:0]               req_addr,
  input  dcache_geom_pkg::ben_t     req_ben,
  input  dcache_geom_pkg::word_t    req_wdata,
  input  dcache_geom_pkg::way_vec_t hit_way,
  input  dcache_geom_pkg::way_t     victim,
  output dcache_geom_pkg::set_t     look_set,
  output dcache_geom_pkg::tag_t     look_tag,
  output logic                      fill_en,
  output dcache_geom_pkg::way_t     fill_way,
  output logic                      touch_en,
  output dcache_geom_pkg::way_t     touch_way,
  output logic [dcache_geom_pkg::WAY_BITS+dcache_geom_pkg::SET_BITS-1:0] bank_idx,
  output logic [dcache_geom_pkg::NUM_BANKS-1:0] bank_rmw,
  output dcache_geom_pkg::ben_t     bank_ben,
  output dcache_geom_pkg::word_t    bank_wdata,
  input  dcache_geom_pkg::word_t [dcache_geom_pkg::NUM_BANKS-1:0] bank_rd,
  output logic                      busy,
  output logic                      resp_valid,
  output logic                      resp_hit,
  output dcache_geom_pkg::word_t    resp_data
);

  logic req_valid;
  dcache_op_pkg::op_t     s1_op;
  dcache_geom_pkg::set_t  s1_set;
  dcache_geom_pkg::off_t  s1_off;
  dcache_geom_pkg::ben_t  s1_ben;
  dcache_geom_pkg::word_t s1_wdata;
  logic s1_hit;
  logic s1_access;
  dcache_geom_pkg::way_t  hit_idx;
  logic s2_resp;
  logic s2_hit;
  dcache_geom_pkg::off_t  s2_off;

  assign busy      = init;
  assign req_valid = (req_op != dcache_op_pkg::OP_NONE) && !init;
  assign look_set  = req_valid ? req_addr[10:5] : '0;
  assign look_tag  = req_valid ? req_addr[31:11] : '0;

  always_ff @(posedge clk) begin
    if (rst) s1_op <= dcache_op_pkg::OP_NONE;
    else s1_op <= req_valid ? req_op : dcache_op_pkg::OP_NONE;
    s1_set   <= req_addr[10:5];
    s1_off   <= req_addr[4:2];
    s1_ben   <= req_ben;
    s1_wdata <= req_wdata;
  end

  always_comb begin
    hit_idx = '0;
    for (int w = 0; w < dcache_geom_pkg::NUM_WAYS; w++)
      if (hit_way[w]) hit_idx = dcache_geom_pkg::way_t'(w);
  end

  assign s1_hit    = |hit_way;
  assign s1_access = (s1_op == dcache_op_pkg::OP_READ) || (s1_op == dcache_op_pkg::OP_WRITE);
  assign fill_en   = (s1_op == dcache_op_pkg::OP_FILL);
  assign fill_way  = victim;
  assign touch_en  = (s1_access && s1_hit) || fill_en;
  assign touch_way = fill_en ? victim : hit_idx;

  // banks register these at the end of stage 1
  assign bank_idx   = {touch_way, s1_set};
  assign bank_ben   = s1_ben;
  assign bank_wdata = s1_wdata;

  always_comb begin
    bank_rmw = '0;
    if (s1_op == dcache_op_pkg::OP_WRITE && s1_hit) bank_rmw[s1_off] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s2_resp    <= 1'b0;
      s2_hit     <= 1'b0;
      resp_valid <= 1'b0;
      resp_hit   <= 1'b0;
    end else begin
      s2_resp    <= s1_access;
      s2_hit     <= s1_hit;
      resp_valid <= s2_resp;
      resp_hit   <= s2_resp && s2_hit;
    end
    s2_off    <= s1_off;
    resp_data <= bank_rd[s2_off]; // word select by offset
  end

  a_no_req_busy: assert property (
    @(posedge clk) disable iff (rst)
    busy |-> req_op == dcache_op_pkg::OP_NONE
  );

endmodule

// File: logic/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
  input  logic                   clk,
  input  logic                   rst,
  input  dcache_op_pkg::op_t     req_op,
  input  logic [31:0]            req_addr,
  input  dcache_geom_pkg::ben_t  req_ben,
  input  dcache_geom_pkg::word_t req_wdata,
  input  dcache_geom_pkg::line_t req_fill,
  output logic                   busy,
  output logic                   resp_valid,
  output logic                   resp_hit,
  output dcache_geom_pkg::word_t resp_data
);

  logic init;
  dcache_geom_pkg::set_t     init_set;
  dcache_geom_pkg::set_t     look_set;
  dcache_geom_pkg::tag_t     look_tag;
  dcache_geom_pkg::way_vec_t hit_way;
  dcache_geom_pkg::way_t     victim;
  logic fill_en;
  dcache_geom_pkg::way_t     fill_way;
  logic touch_en;
  dcache_geom_pkg::way_t     touch_way;
  logic [dcache_geom_pkg::WAY_BITS+dcache_geom_pkg::SET_BITS-1:0] bank_idx;
  logic [dcache_geom_pkg::NUM_BANKS-1:0] bank_rmw;
  dcache_geom_pkg::ben_t     bank_ben;
  dcache_geom_pkg::word_t    bank_wdata;
  dcache_geom_pkg::word_t [dcache_geom_pkg::NUM_BANKS-1:0] bank_rd;

  dcache_init_seq init_mod (
    .clk(clk), .rst(rst), .init(init), .init_set(init_set)
  );

  dcache_tag_array tag_mod (
    .clk(clk), .rst(rst), .init(init), .init_set(init_set),
    .look_set(look_set), .look_tag(look_tag),
    .fill_en(fill_en), .fill_way(fill_way), .hit_way(hit_way)
  );

  dcache_lru_array lru_mod (
    .clk(clk), .rst(rst), .init(init), .init_set(init_set),
    .look_set(look_set), .touch_en(touch_en), .touch_way(touch_way),
    .victim(victim)
  );

  dcache_ctrl ctrl_mod (
    .clk(clk), .rst(rst), .init(init),
    .req_op(req_op), .req_addr(req_addr), .req_ben(req_ben), .req_wdata(req_wdata),
    .hit_way(hit_way), .victim(victim), .look_set(look_set), .look_tag(look_tag),
    .fill_en(fill_en), .fill_way(fill_way), .touch_en(touch_en), .touch_way(touch_way),
    .bank_idx(bank_idx), .bank_rmw(bank_rmw), .bank_ben(bank_ben),
    .bank_wdata(bank_wdata), .bank_rd(bank_rd),
    .busy(busy), .resp_valid(resp_valid), .resp_hit(resp_hit), .resp_data(resp_data)
  );

  // bank b holds word b of every line
  for (genvar b = 0; b < dcache_geom_pkg::NUM_BANKS; b++) begin : bank_gen
    dcache_bank bank_mod (
      .clk(clk), .rst(rst), .idx(bank_idx),
      .rmw_en(bank_rmw[b]), .ben(bank_ben), .wdata(bank_wdata),
      .fill_en(fill_en),
      .fill_word(req_fill[b*dcache_geom_pkg::WORD_BITS +: dcache_geom_pkg::WORD_BITS]),
      .rd_data(bank_rd[b])
    );
  end

endmodule

// File: tests/dcache_model.svh
`ifndef DCACHE_MODEL_SVH
`define DCACHE_MODEL_SVH

// cache state indexed [way][set]
dcache_geom_pkg::tag_t  m_tag   [dcache_geom_pkg::NUM_WAYS][dcache_geom_pkg::NUM_SETS];
logic                   m_valid [dcache_geom_pkg::NUM_WAYS][dcache_geom_pkg::NUM_SETS];
dcache_geom_pkg::age_t  m_age   [dcache_geom_pkg::NUM_WAYS][dcache_geom_pkg::NUM_SETS];
dcache_geom_pkg::word_t m_data  [dcache_geom_pkg::NUM_WAYS][dcache_geom_pkg::NUM_SETS]
                                [dcache_geom_pkg::NUM_BANKS];

function automatic void clear_model();
  for (int w = 0; w < dcache_geom_pkg::NUM_WAYS; w++)
    for (int s = 0; s < dcache_geom_pkg::NUM_SETS; s++) begin
      m_valid[w][s] = 1'b0;
      m_age[w][s]   = dcache_geom_pkg::age_t'(w); // way w starts at age w
    end
endfunction

function automatic logic find_way(logic [31:0] addr, output dcache_geom_pkg::way_t way);
  dcache_geom_pkg::set_t set;
  logic hit;
  set = addr[10:5];
  hit = 1'b0;
  way = '0;
  for (int w = 0; w < dcache_geom_pkg::NUM_WAYS; w++)
    if (m_valid[w][set] && m_tag[w][set] == addr[31:11]) begin
      hit = 1'b1;
      way = dcache_geom_pkg::way_t'(w);
    end
  return hit;
endfunction

// touched way to age 0, younger ways one older
function automatic void touch_ages(dcache_geom_pkg::set_t set, dcache_geom_pkg::way_t way);
  dcache_geom_pkg::age_t old;
  old = m_age[way][set];
  for (int w = 0; w < dcache_geom_pkg::NUM_WAYS; w++)
    if (m_age[w][set] < old) m_age[w][set] = m_age[w][set] + 1'b1;
  m_age[way][set] = '0;
endfunction

function automatic void install_line(logic [31:0] addr, dcache_geom_pkg::line_t line);
  dcache_geom_pkg::set_t set;
  dcache_geom_pkg::way_t victim;
  set = addr[10:5];
  victim = '0;
  for (int w = 0; w < dcache_geom_pkg::NUM_WAYS; w++)
    if (m_age[w][set] == 2'd3) victim = dcache_geom_pkg::way_t'(w);
  m_tag[victim][set]   = addr[31:11];
  m_valid[victim][set] = 1'b1;
  for (int b = 0; b < dcache_geom_pkg::NUM_BANKS; b++)
    m_data[victim][set][b] = line[b*dcache_geom_pkg::WORD_BITS +: dcache_geom_pkg::WORD_BITS];
  touch_ages(set, victim);
endfunction

// expected hit and word for a read or write; a write hit merges its bytes
function automatic logic predict_access(logic [31:0] addr, logic is_write,
                                        dcache_geom_pkg::ben_t ben, dcache_geom_pkg::word_t wdata,
                                        output dcache_geom_pkg::word_t rdata);
  dcache_geom_pkg::set_t set;
  dcache_geom_pkg::off_t off;
  dcache_geom_pkg::way_t way;
  logic hit;
  set = addr[10:5];
  off = addr[4:2];
  rdata = '0;
  hit = find_way(addr, way);
  if (hit) begin
    rdata = m_data[way][set][off];
    if (is_write)
      for (int i = 0; i < 4; i++)
        if (ben[i]) m_data[way][set][off][8*i +: 8] = wdata[8*i +: 8];
    touch_ages(set, way);
  end
  return hit;
endfunction

function automatic logic [31:0] xorshift(logic [31:0] x);
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

`endif

// File: tests/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

  localparam int NUM_RAND    = 400;
  localparam int NUM_REQS    = NUM_RAND + 40; // directed requests included
  localparam int WATCHDOG_NS = NUM_REQS * 20 + 2000;

  typedef struct packed {
    logic [31:0]            due;
    logic                   hit;
    logic                   is_read;
    dcache_geom_pkg::word_t data;
  } expect_t;

  logic clk;
  logic rst;
  dcache_op_pkg::op_t     req_op;
  logic [31:0]            req_addr;
  dcache_geom_pkg::ben_t  req_ben;
  dcache_geom_pkg::word_t req_wdata;
  dcache_geom_pkg::line_t req_fill;
  logic busy;
  logic resp_valid;
  logic resp_hit;
  dcache_geom_pkg::word_t resp_data;

  int cyc;
  int errors;
  int busy_cycles;
  logic [31:0] rng;
  expect_t pending[$];

  `include "dcache_model.svh"

  dcache_top dut0 (
    .clk(clk), .rst(rst), .req_op(req_op), .req_addr(req_addr), .req_ben(req_ben),
    .req_wdata(req_wdata), .req_fill(req_fill), .busy(busy), .resp_valid(resp_valid),
    .resp_hit(resp_hit), .resp_data(resp_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  task automatic check(string what, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  function automatic logic [31:0] make_addr(dcache_geom_pkg::tag_t tag,
                                            dcache_geom_pkg::set_t set,
                                            dcache_geom_pkg::off_t off);
    return {tag, set, off, 2'b00};
  endfunction

  function automatic dcache_geom_pkg::line_t rand_line();
    dcache_geom_pkg::line_t line;
    for (int b = 0; b < dcache_geom_pkg::NUM_BANKS; b++) begin
      rng = xorshift(rng);
      line[b*dcache_geom_pkg::WORD_BITS +: dcache_geom_pkg::WORD_BITS] = rng;
    end
    return line;
  endfunction

  task automatic idle(int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      req_op = dcache_op_pkg::OP_NONE;
    end
  endtask

  task automatic issue(dcache_op_pkg::op_t op, logic [31:0] addr, dcache_geom_pkg::ben_t ben,
                       dcache_geom_pkg::word_t wdata, dcache_geom_pkg::line_t line);
    expect_t e;
    dcache_geom_pkg::word_t d;
    @(posedge clk);
    #1;
    req_op    = op;
    req_addr  = addr;
    req_ben   = ben;
    req_wdata = wdata;
    req_fill  = line;
    if (op == dcache_op_pkg::OP_FILL) begin
      install_line(addr, line);
    end else begin
      e.due     = cyc + 3; // sampled next edge, answered two edges later
      e.is_read = (op == dcache_op_pkg::OP_READ);
      e.hit     = predict_access(addr, !e.is_read, ben, wdata, d);
      e.data    = d;
      pending.push_back(e);
    end
  endtask

  // writes and fills need two idle cycles on each side
  task automatic spaced(dcache_op_pkg::op_t op, logic [31:0] addr, dcache_geom_pkg::ben_t ben,
                        dcache_geom_pkg::word_t wdata, dcache_geom_pkg::line_t line);
    idle(2);
    issue(op, addr, ben, wdata, line);
    idle(2);
  endtask

  always @(negedge clk) begin : compare
    expect_t e;
    if (resp_valid) begin
      if (pending.size() == 0) begin
        $display("Error at %0t: response valid with no request outstanding", $time);
        errors++;
      end else begin
        e = pending.pop_front();
        check("response cycle", cyc, e.due);
        check("resp_hit", resp_hit, e.hit);
        if (e.is_read && e.hit) check("resp_data", resp_data, e.data);
      end
    end else if (pending.size() > 0 && pending[0].due < cyc) begin
      $display("Error at %0t: expected response did not arrive", $time);
      errors++;
      void'(pending.pop_front());
    end
  end

  initial begin
    logic [31:0] addr;
    logic [31:0] miss_addr;
    dcache_geom_pkg::way_t dummy_way;
    rng       = 32'h573b_7b0c;
    rst       = 1'b1;
    req_op    = dcache_op_pkg::OP_NONE;
    req_addr  = '0;
    req_ben   = '0;
    req_wdata = '0;
    req_fill  = '0;
    clear_model();
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;

    busy_cycles = 0;
    while (busy === 1'b1 && busy_cycles <= 2 * dcache_geom_pkg::NUM_SETS) begin
      @(negedge clk);
      if (busy) busy_cycles++;
    end
    check("busy cycles after reset", busy_cycles, dcache_geom_pkg::NUM_SETS);

    // cold cache
    for (int i = 0; i < 8; i++) begin
      rng = xorshift(rng);
      issue(dcache_op_pkg::OP_READ, rng, '0, '0, '0);
    end

    addr = make_addr(21'h1abcd, 6'd3, 3'd0);
    spaced(dcache_op_pkg::OP_FILL, addr, '0, '0, rand_line());
    for (int b = 0; b < dcache_geom_pkg::NUM_BANKS; b++)
      issue(dcache_op_pkg::OP_READ, addr + 4 * b, '0, '0, '0);

    rng = xorshift(rng);
    spaced(dcache_op_pkg::OP_WRITE, addr + 8, 4'b0101, rng, '0);
    issue(dcache_op_pkg::OP_READ, addr + 8, '0, '0, '0);
    miss_addr = make_addr(21'h1abce, 6'd3, 3'd2);
    spaced(dcache_op_pkg::OP_WRITE, miss_addr, 4'hf, ~rng, '0);
    issue(dcache_op_pkg::OP_READ, miss_addr, '0, '0, '0);
    issue(dcache_op_pkg::OP_READ, addr + 8, '0, '0, '0);

    // five lines into one set, the first one gets evicted
    for (int t = 0; t < 5; t++)
      spaced(dcache_op_pkg::OP_FILL, make_addr(21'h200 + t, 6'd17, 3'd1), '0, '0, rand_line());
    for (int t = 0; t < 5; t++)
      issue(dcache_op_pkg::OP_READ, make_addr(21'h200 + t, 6'd17, 3'd1), '0, '0, '0);

    for (int i = 0; i < NUM_RAND; i++) begin
      rng = xorshift(rng);
      addr = make_addr(dcache_geom_pkg::tag_t'(21'h40 + rng[2:0]),
                       dcache_geom_pkg::set_t'({rng[4:3], 4'h9}),
                       dcache_geom_pkg::off_t'(rng[7:5]));
      if (rng[12:11] != 2'b11 && rng[12:10] >= 3'd4)
        spaced(dcache_op_pkg::OP_WRITE, addr, rng[16:13], xorshift(rng), '0);
      else if (rng[12:11] == 2'b11 && !find_way(addr, dummy_way))
        spaced(dcache_op_pkg::OP_FILL, addr, '0, '0, rand_line());
      else
        issue(dcache_op_pkg::OP_READ, addr, '0, '0, '0);
    end
    idle(6);

    if (pending.size() != 0) begin
      $display("Error: %0d responses never arrived", pending.size());
      errors++;
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: simulation still running after %0d ns", WATCHDOG_NS);
    $display("errors: %0d", errors);
    $display("** FAIL **");
    $finish;
  end

endmodule

// File: src.f
+incdir+tests
logic/dcache_geom_pkg.sv
logic/dcache_op_pkg.sv
logic/dcache_init_seq.sv
logic/dcache_tag_array.sv
logic/dcache_lru_array.sv
logic/dcache_bank.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
tests/dcache_tb.sv
